// ==== verilog/soc_pkg.sv ====
/*
 * SoC shared definitions
 * Host bus request/response structs, device map, register offsets and sizes
 */
`default_nettype none

package soc_pkg;

    // Master to device
    typedef struct packed {
        logic        valid;
        logic [31:0] address;
        logic [3:0]  wstrobe;
        logic [31:0] wdata;
    } bus_req_t;

    // Device to master
    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } bus_rsp_t;

    // Device codes from address bits 31 to 24
    localparam logic [7:0] dev_ram   = 8'h00;
    localparam logic [7:0] dev_timer = 8'h80;
    localparam logic [7:0] dev_uart  = 8'h81;

    localparam int ram_size_words = 256;
    localparam int ram_addr_bits  = 8;

    // Register offsets in address bits 7 to 0
    localparam logic [7:0] timer_reg_counter = 8'h00;
    localparam logic [7:0] timer_reg_compare = 8'h04;
    localparam logic [7:0] timer_reg_control = 8'h08;
    localparam logic [7:0] uart_reg_data     = 8'h00;
    localparam logic [7:0] uart_reg_status   = 8'h04;

    // UART bit timing
    localparam int uart_clks_per_bit = 16;
    localparam int uart_cnt_bits     = $clog2(uart_clks_per_bit);
    localparam logic [uart_cnt_bits-1:0] uart_bit_last  = uart_cnt_bits'(uart_clks_per_bit - 1);
    localparam logic [uart_cnt_bits-1:0] uart_half_last =
        uart_cnt_bits'(uart_clks_per_bit / 2 - 1);

endpackage

`default_nettype wire

// ==== verilog/soc_bus_decoder.sv ====
/*
 * Host bus decoder
 * Routes a request to RAM, timer or UART by device code and muxes the reply
 */
`timescale 1ns/1ns
`default_nettype none

module soc_bus_decoder (
    input  soc_pkg::bus_req_t host_req,
    output soc_pkg::bus_rsp_t host_rsp,
    output soc_pkg::bus_req_t ram_req,
    output soc_pkg::bus_req_t timer_req,
    output soc_pkg::bus_req_t uart_req,
    input  soc_pkg::bus_rsp_t ram_rsp,
    input  soc_pkg::bus_rsp_t timer_rsp,
    input  soc_pkg::bus_rsp_t uart_rsp
);

    logic [7:0] dev_code;

    assign dev_code = host_req.address[31:24];

    // Address, strobes and data go everywhere but valid only to the selected device
    always_comb begin
        ram_req         = host_req;
        timer_req       = host_req;
        uart_req        = host_req;
        ram_req.valid   = host_req.valid && (dev_code == soc_pkg::dev_ram);
        timer_req.valid = host_req.valid && (dev_code == soc_pkg::dev_timer);
        uart_req.valid  = host_req.valid && (dev_code == soc_pkg::dev_uart);
    end

    always_comb begin
        case (dev_code)
            soc_pkg::dev_ram: begin
                host_rsp = ram_rsp;
            end
            soc_pkg::dev_timer: begin
                host_rsp = timer_rsp;
            end
            soc_pkg::dev_uart: begin
                host_rsp = uart_rsp;
            end
            default: begin
                // Nothing mapped here so answer at once with zero
                host_rsp.ready = host_req.valid;
                host_rsp.rdata = 32'h0000_0000;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/soc_ram.sv ====
/*
 * Single-port word RAM
 * Byte write strobes, read data registered with the one-cycle ready
 */
`timescale 1ns/1ns
`default_nettype none

module soc_ram (
    input  bit                clk,
    input  bit                arst_n,
    input  soc_pkg::bus_req_t req,
    output soc_pkg::bus_rsp_t rsp
);

    logic [31:0]                       mem [soc_pkg::ram_size_words];
    logic [soc_pkg::ram_addr_bits-1:0] index;
    logic                              ready;
    logic [31:0]                       rdata;

    // Word index from address bits 9 to 2
    assign index = req.address[soc_pkg::ram_addr_bits+1:2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready <= 1'b0;
        end else begin
            ready <= req.valid && !ready;
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid && !ready) begin
            for (int i = 0; i < 4; i++) begin
                if (req.wstrobe[i]) begin
                    mem[index][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
            rdata <= mem[index];
        end
    end

    assign rsp = '{ready: ready, rdata: rdata};

endmodule

`default_nettype wire

// ==== verilog/soc_timer.sv ====
/*
 * Timer peripheral
 * Free-running counter with a compare register and a level interrupt
 */
`timescale 1ns/1ns
`default_nettype none

module soc_timer (
    input  bit                clk,
    input  bit                arst_n,
    input  soc_pkg::bus_req_t req,
    output soc_pkg::bus_rsp_t rsp,
    output bit                irq
);

    logic        ready;
    logic [31:0] rdata;
    logic [31:0] counter;
    logic [31:0] compare;
    logic        enable;
    logic        pending;
    logic        access;
    logic        write;
    logic [7:0]  reg_offset;

    // Merge new bytes over an old word
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strobe);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strobe[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    assign reg_offset = req.address[7:0];
    assign access     = req.valid && !ready;
    assign write      = access && (req.wstrobe != 4'b0000);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready   <= 1'b0;
            counter <= 32'd0;
            compare <= 32'd0;
            enable  <= 1'b0;
            pending <= 1'b0;
        end else begin
            ready   <= access;
            counter <= counter + 32'd1;
            if (write && reg_offset == soc_pkg::timer_reg_counter) begin
                counter <= merge_bytes(counter, req.wdata, req.wstrobe);
            end
            if (write && reg_offset == soc_pkg::timer_reg_compare) begin
                compare <= merge_bytes(compare, req.wdata, req.wstrobe);
            end
            if (write && reg_offset == soc_pkg::timer_reg_control && req.wstrobe[0]) begin
                enable <= req.wdata[0];
                // Write one to clear
                if (req.wdata[1]) begin
                    pending <= 1'b0;
                end
            end
            // A match in the same cycle wins over a clear
            if (enable && counter == compare) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (reg_offset)
                soc_pkg::timer_reg_counter: rdata <= counter;
                soc_pkg::timer_reg_compare: rdata <= compare;
                soc_pkg::timer_reg_control: rdata <= {30'd0, pending, enable};
                default:                    rdata <= 32'd0;
            endcase
        end
    end

    assign rsp = '{ready: ready, rdata: rdata};
    assign irq = pending && enable;

endmodule

`default_nettype wire

// ==== verilog/soc_uart.sv ====
/*
 * 8N1 UART peripheral
 * Transmit and receive shifters behind a data and a status register
 */
`timescale 1ns/1ns
`default_nettype none

module soc_uart (
    input  bit                clk,
    input  bit                arst_n,
    input  soc_pkg::bus_req_t req,
    output soc_pkg::bus_rsp_t rsp,
    output bit                tx,
    input  bit                rx
);

    logic        ready;
    logic [31:0] rdata;
    logic        access;
    logic [7:0]  reg_offset;
    logic        tx_start;
    logic        data_read;

    logic                              tx_busy;
    logic [9:0]                        tx_shift;
    logic [3:0]                        tx_bit_cnt;
    logic [soc_pkg::uart_cnt_bits-1:0] tx_clk_cnt;

    logic                              rx_meta;
    logic                              rx_sync;
    logic                              rx_prev;
    logic                              rx_busy;
    logic [3:0]                        rx_bit_cnt;
    logic [soc_pkg::uart_cnt_bits-1:0] rx_clk_cnt;
    logic [7:0]                        rx_shift;
    logic                              rx_done;
    logic [7:0]                        rx_data;
    logic                              rx_valid;

    assign reg_offset = req.address[7:0];
    assign access     = req.valid && !ready;
    // Writes while a frame is going out are dropped
    assign tx_start   = access && req.wstrobe[0] && !tx_busy
                        && reg_offset == soc_pkg::uart_reg_data;
    assign data_read  = access && req.wstrobe == 4'b0000
                        && reg_offset == soc_pkg::uart_reg_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready <= 1'b0;
        end else begin
            ready <= access;
        end
    end

    // Transmitter shifts frame bits out LSB first
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_busy    <= 1'b0;
            tx_shift   <= '1;
            tx_bit_cnt <= 4'd0;
            tx_clk_cnt <= '0;
        end else if (tx_start) begin
            tx_busy    <= 1'b1;
            tx_shift   <= {1'b1, req.wdata[7:0], 1'b0};
            tx_bit_cnt <= 4'd0;
            tx_clk_cnt <= soc_pkg::uart_bit_last;
        end else if (tx_busy) begin
            if (tx_clk_cnt == '0) begin
                tx_shift   <= {1'b1, tx_shift[9:1]};
                tx_clk_cnt <= soc_pkg::uart_bit_last;
                tx_bit_cnt <= tx_bit_cnt + 4'd1;
                if (tx_bit_cnt == 4'd9) begin
                    tx_busy <= 1'b0;
                end
            end else begin
                tx_clk_cnt <= tx_clk_cnt - 1'b1;
            end
        end
    end

    assign tx = tx_shift[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // Receiver bit 0 is start with 1 to 8 data and 9 stop
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_busy    <= 1'b0;
            rx_bit_cnt <= 4'd0;
            rx_clk_cnt <= '0;
        end else if (!rx_busy) begin
            if (rx_prev && !rx_sync) begin
                rx_busy    <= 1'b1;
                rx_bit_cnt <= 4'd0;
                rx_clk_cnt <= soc_pkg::uart_half_last;
            end
        end else if (rx_clk_cnt == '0) begin
            rx_clk_cnt <= soc_pkg::uart_bit_last;
            rx_bit_cnt <= rx_bit_cnt + 4'd1;
            // Start bit glitch returns to idle
            if ((rx_bit_cnt == 4'd0 && rx_sync) || rx_bit_cnt == 4'd9) begin
                rx_busy <= 1'b0;
            end
        end else begin
            rx_clk_cnt <= rx_clk_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_busy && rx_clk_cnt == '0 && rx_bit_cnt >= 4'd1 && rx_bit_cnt <= 4'd8) begin
            rx_shift <= {rx_sync, rx_shift[7:1]};
        end
    end

    // Mid stop bit with a valid stop level
    assign rx_done = rx_busy && rx_clk_cnt == '0 && rx_bit_cnt == 4'd9 && rx_sync;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_valid <= 1'b0;
        end else if (rx_done) begin
            rx_valid <= 1'b1;
        end else if (data_read) begin
            rx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_done) begin
            rx_data <= rx_shift;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (reg_offset)
                soc_pkg::uart_reg_data:   rdata <= {24'd0, rx_data};
                soc_pkg::uart_reg_status: rdata <= {30'd0, rx_valid, tx_busy};
                default:                  rdata <= 32'd0;
            endcase
        end
    end

    assign rsp = '{ready: ready, rdata: rdata};

endmodule

`default_nettype wire

// ==== verilog/simple_soc.sv ====
/*
 * Simple SoC device side
 * Host bus decoder in front of RAM, timer and UART
 */
`timescale 1ns/1ns
`default_nettype none

module simple_soc (
    input  bit                clk,
    input  bit                arst_n,
    input  soc_pkg::bus_req_t host_req,
    output soc_pkg::bus_rsp_t host_rsp,
    output bit                irq,
    output bit                uart_tx,
    input  bit                uart_rx
);

    soc_pkg::bus_req_t ram_req;
    soc_pkg::bus_req_t timer_req;
    soc_pkg::bus_req_t uart_req;
    soc_pkg::bus_rsp_t ram_rsp;
    soc_pkg::bus_rsp_t timer_rsp;
    soc_pkg::bus_rsp_t uart_rsp;

    soc_bus_decoder decoder_i (
        .host_req  (host_req),
        .host_rsp  (host_rsp),
        .ram_req   (ram_req),
        .timer_req (timer_req),
        .uart_req  (uart_req),
        .ram_rsp   (ram_rsp),
        .timer_rsp (timer_rsp),
        .uart_rsp  (uart_rsp)
    );

    soc_ram ram_i (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (ram_req),
        .rsp    (ram_rsp)
    );

    // Timer interrupt goes straight to the host
    soc_timer timer_i (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (timer_req),
        .rsp    (timer_rsp),
        .irq    (irq)
    );

    soc_uart uart_i (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (uart_req),
        .rsp    (uart_rsp),
        .tx     (uart_tx),
        .rx     (uart_rx)
    );

endmodule

`default_nettype wire

// ==== testbench/simple_soc_tb.sv ====
/*
 * Testbench for the simple SoC device side
 * Acts as the host bus master and checks RAM, decoder, timer and UART
 */
`timescale 1ns/1ns
`default_nettype none

module simple_soc_tb;

    localparam logic [31:0] unmapped_addr    = 32'h4200_0000;
    localparam logic [31:0] timer_base       = {soc_pkg::dev_timer, 24'h000000};
    localparam logic [31:0] uart_data_addr   =
        {soc_pkg::dev_uart, 16'h0000, soc_pkg::uart_reg_data};
    localparam logic [31:0] uart_status_addr =
        {soc_pkg::dev_uart, 16'h0000, soc_pkg::uart_reg_status};
    localparam int frame_cycles   = 10 * soc_pkg::uart_clks_per_bit;
    localparam int timer_wait     = 250;
    localparam int ram_test_len   = (16 + 8 + 16) * 3;
    localparam int timeout_cycles = 4 * (ram_test_len + 2 * frame_cycles + timer_wait);

    logic              clk;
    logic              arst_n;
    soc_pkg::bus_req_t host_req;
    soc_pkg::bus_rsp_t host_rsp;
    logic              irq;
    logic              uart_tx;
    logic              uart_rx;
    logic              rx_force_en;
    logic              req_mapped;
    logic [15:0]       lfsr;
    logic [31:0]       ram_model [16];
    int                checks;
    int                errors;
    int                tests_run;
    int                cycle_count;

    simple_soc dut_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .irq      (irq),
        .uart_tx  (uart_tx),
        .uart_rx  (uart_rx)
    );

    // Loopback unless the testbench holds the rx line idle
    assign uart_rx    = rx_force_en ? 1'b1 : uart_tx;
    assign req_mapped = host_req.address[31:24] == soc_pkg::dev_ram
                        || host_req.address[31:24] == soc_pkg::dev_timer
                        || host_req.address[31:24] == soc_pkg::dev_uart;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    assert property (@(negedge clk) !arst_n |-> !host_rsp.ready && !irq && uart_tx)
        else begin
            errors++;
            $display("FAIL ready/irq/uart_tx in reset got %h %h %h expected 0 0 1",
                     host_rsp.ready, irq, uart_tx);
        end

    assert property (@(posedge clk) disable iff (!arst_n)
        $rose(host_req.valid) && req_mapped |-> !host_rsp.ready ##1 host_rsp.ready)
        else begin
            errors++;
            $display("mapped access at %h did not get ready one cycle after valid",
                     host_req.address);
        end

    // Ready is a single-cycle pulse
    assert property (@(posedge clk) disable iff (!arst_n) host_rsp.ready |=> !host_rsp.ready)
        else begin
            errors++;
            $display("FAIL host_rsp.ready got %h expected 0 after a ready cycle",
                     host_rsp.ready);
        end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        value = 32'd0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] ram_address(input int word);
        return {soc_pkg::dev_ram, 14'd0, 8'(word * 17), 2'b00};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, expected);
        end
    endtask

    // One handshake with ready looked at on the falling edge
    task automatic bus_access(input logic [31:0] addr, input logic [3:0] strobe,
                              input logic [31:0] data, output logic [31:0] rdata);
        int   latency;
        logic mapped;
        latency = 0;
        mapped  = addr[31:24] == soc_pkg::dev_ram || addr[31:24] == soc_pkg::dev_timer
                  || addr[31:24] == soc_pkg::dev_uart;
        @(posedge clk);
        #2;
        host_req = '{valid: 1'b1, address: addr, wstrobe: strobe, wdata: data};
        @(negedge clk);
        while (!host_rsp.ready && latency < 8) begin
            @(negedge clk);
            latency++;
        end
        rdata = host_rsp.rdata;
        assert (host_rsp.ready) else begin
            errors++;
            $display("device at address %h never answered", addr);
        end
        check_value("host_rsp.ready latency", latency, mapped ? 1 : 0);
        @(posedge clk);
        #2;
        host_req.valid = 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [3:0] strobe,
                             input logic [31:0] data);
        logic [31:0] unused;
        bus_access(addr, strobe, data, unused);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
        bus_access(addr, 4'b0000, 32'd0, rdata);
    endtask

    // Poll the UART status until a bit reaches a level
    task automatic wait_uart_status(input string name, input int bit_index,
                                    input logic level, input int max_polls);
        logic [31:0] status;
        int          polls;
        polls = 0;
        bus_read(uart_status_addr, status);
        while (status[bit_index] !== level && polls < max_polls) begin
            bus_read(uart_status_addr, status);
            polls++;
        end
        check_value(name, status[bit_index], level);
    endtask

    // Mid-bit samples of one frame right after the write completes
    task automatic sample_tx_frame(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        repeat (soc_pkg::uart_clks_per_bit / 2) @(negedge clk);
        for (int i = 0; i < 10; i++) begin
            check_value($sformatf("uart_tx bit %0d", i), uart_tx, frame[i]);
            if (i < 9) begin
                repeat (soc_pkg::uart_clks_per_bit) @(negedge clk);
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the tests did not finish", cycle_count);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] value;
        logic [31:0] rd;
        logic [31:0] pick;
        logic [31:0] strobe;
        logic [31:0] count_a;
        logic [7:0]  byte_a;
        logic [7:0]  byte_b;
        int          start_errors;
        int          wait_count;

        host_req     = '0;
        arst_n       = 1'b0;
        rx_force_en  = 1'b1;
        lfsr         = 16'd18594;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;

        start_errors = errors;
        repeat (16) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(negedge clk);
        check_value("host_rsp.ready", host_rsp.ready, 0);
        check_value("irq", irq, 0);
        check_value("uart_tx", uart_tx, 1);
        report_test("reset state", start_errors);

        start_errors = errors;
        for (int i = 0; i < 16; i++) begin
            random_bits(32, value);
            ram_model[i] = value;
            bus_write(ram_address(i), 4'hf, value);
        end
        // Partial overwrites through byte strobes
        for (int i = 0; i < 8; i++) begin
            random_bits(4, pick);
            random_bits(4, strobe);
            random_bits(32, value);
            for (int b = 0; b < 4; b++) begin
                if (strobe[b]) begin
                    ram_model[pick][8*b +: 8] = value[8*b +: 8];
                end
            end
            bus_write(ram_address(pick), strobe[3:0], value);
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(ram_address(i), rd);
            check_value($sformatf("ram word %0d", i), rd, ram_model[i]);
        end
        report_test("ram", start_errors);

        start_errors = errors;
        bus_read(unmapped_addr, rd);
        check_value("unmapped rdata", rd, 0);
        bus_write(unmapped_addr, 4'hf, 32'hdead_beef);
        bus_read(ram_address(0), rd);
        check_value("ram word 0", rd, ram_model[0]);
        report_test("unmapped device", start_errors);

        start_errors = errors;
        bus_read(timer_base + soc_pkg::timer_reg_counter, count_a);
        bus_read(timer_base + soc_pkg::timer_reg_counter, rd);
        check_value("counter increasing", rd > count_a, 1);
        bus_write(timer_base + soc_pkg::timer_reg_compare, 4'hf, rd + 32'd200);
        bus_write(timer_base + soc_pkg::timer_reg_control, 4'hf, 32'h1);
        wait_count = 0;
        while (!irq && wait_count < timer_wait) begin
            @(negedge clk);
            wait_count++;
        end
        check_value("irq", irq, 1);
        bus_read(timer_base + soc_pkg::timer_reg_control, rd);
        check_value("timer pending", rd[1], 1);
        bus_write(timer_base + soc_pkg::timer_reg_control, 4'hf, 32'h3);
        @(negedge clk);
        check_value("irq", irq, 0);
        bus_read(timer_base + soc_pkg::timer_reg_control, rd);
        check_value("timer control", rd, 32'h1);
        report_test("timer", start_errors);

        // Receiver held idle so this frame is not picked up
        start_errors = errors;
        random_bits(8, value);
        byte_a = value[7:0];
        bus_write(uart_data_addr, 4'h1, {24'd0, byte_a});
        fork
            sample_tx_frame(byte_a);
            begin
                repeat (4) @(posedge clk);
                bus_read(uart_status_addr, rd);
                check_value("uart tx_busy", rd[0], 1);
            end
        join
        wait_uart_status("uart tx_busy", 0, 1'b0, 20);
        report_test("uart transmit", start_errors);

        start_errors = errors;
        rx_force_en = 1'b0;
        random_bits(8, value);
        byte_a = value[7:0];
        byte_b = ~byte_a;
        bus_write(uart_data_addr, 4'h1, {24'd0, byte_a});
        bus_write(uart_data_addr, 4'h1, {24'd0, byte_b});
        wait_uart_status("uart rx_valid", 1, 1'b1, 80);
        bus_read(uart_data_addr, rd);
        check_value("uart rx data", rd, {24'd0, byte_a});
        bus_read(uart_status_addr, rd);
        check_value("uart rx_valid", rd[1], 0);
        wait_uart_status("uart tx_busy", 0, 1'b0, 20);
        // A second frame would have landed by now
        repeat (frame_cycles) @(posedge clk);
        bus_read(uart_status_addr, rd);
        check_value("uart status", rd, 0);
        report_test("uart loopback", start_errors);

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== simple_soc.f ====
verilog/soc_pkg.sv
verilog/soc_bus_decoder.sv
verilog/soc_ram.sv
verilog/soc_timer.sv
verilog/soc_uart.sv
verilog/simple_soc.sv
testbench/simple_soc_tb.sv
